//--- dv/sdram_ctrl_properties.sv
`timescale 1ns/1ns

module sdram_ctrl_properties #(
  parameter int INIT_WAIT_CYC = 20000
) (
  input logic clk_i,
  input logic rst_i,
  input logic ack_o,
  input logic cs_n_o,
  input logic ras_n_o,
  input logic cas_n_o,
  input logic we_n_o,
  input logic [sdram_pkg::SEL_W-1:0] dqm_o
);

  logic [3:0] cmd;
  int wait_cnt_q; // clocks since reset release, saturating
  int assert_fails = 0;

  assign cmd = {cs_n_o, ras_n_o, cas_n_o, we_n_o};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wait_cnt_q <= 0;
    end else if (wait_cnt_q < INIT_WAIT_CYC) begin
      wait_cnt_q <= wait_cnt_q + 1;
    end
  end

  ack_single: assert property (@(posedge clk_i) disable iff (rst_i) ack_o |=> !ack_o)
    else begin
      assert_fails++;
      $error("ack_o held longer than one cycle");
    end

  nop_in_reset: assert property (@(posedge clk_i) rst_i |-> cmd == sdram_pkg::CMD_NOP)
    else begin
      assert_fails++;
      $error("command other than NOP during reset");
    end

  nop_in_wait: assert property (@(posedge clk_i) disable iff (rst_i)
    (wait_cnt_q < INIT_WAIT_CYC) |-> cmd == sdram_pkg::CMD_NOP)
    else begin
      assert_fails++;
      $error("command other than NOP during the power-up wait");
    end

  dqm_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    !(cmd == sdram_pkg::CMD_READ || cmd == sdram_pkg::CMD_WRITE) |-> dqm_o == '1)
    else begin
      assert_fails++;
      $error("dqm not all ones outside a column access");
    end

endmodule

//--- dv/sdram_ctrl_tb.sv
`timescale 1ns/1ns

module sdram_ctrl_tb;

  localparam int INIT_WAIT = 50;
  localparam int GAP_CYC = 20;      // idle clocks between records
  localparam int MAX_REC = 64;

  logic clk_i = 1'b0;
  logic rst_i;
  logic cyc_i, stb_i, we_i;
  logic [24:0] adr_i;
  logic [3:0] sel_i;
  logic [31:0] dat_i, dat_o, dq_i, dq_o;
  logic ack_o, mem_clk, cke, cs_n, ras_n, cas_n, we_n;
  logic [1:0] ba;
  logic [12:0] addr;
  logic [3:0] dqm;
  int model_errs, ref_cnt;
  logic init_done;
  logic [3:0] pin_cmd;

  logic [3:0] rec_op [MAX_REC];
  logic [24:0] rec_adr [MAX_REC];
  logic [3:0] rec_sel [MAX_REC];
  logic [31:0] rec_dat [MAX_REC];
  int n_rec = 0;
  logic loaded = 1'b0;
  logic [31:0] shadow [int];
  int mismatches = 0;
  int other_errs = 0;
  int ack_cnt = 0;

  always #20 clk_i = ~clk_i;

  assign pin_cmd = {cs_n, ras_n, cas_n, we_n};

  sdram_ctrl_top #(.INIT_WAIT_CYC(INIT_WAIT)) i_sdram_ctrl_top (
    .clk_i(clk_i), .rst_i(rst_i), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
    .adr_i(adr_i), .sel_i(sel_i), .dat_i(dat_i), .dat_o(dat_o), .ack_o(ack_o),
    .mem_clk_o(mem_clk), .cke_o(cke), .cs_n_o(cs_n), .ras_n_o(ras_n),
    .cas_n_o(cas_n), .we_n_o(we_n), .ba_o(ba), .addr_o(addr), .dqm_o(dqm),
    .dq_i(dq_i), .dq_o(dq_o)
  );

  sdram_model i_model (
    .mem_clk_i(mem_clk), .rst_i(rst_i), .cke_i(cke), .cs_n_i(cs_n), .ras_n_i(ras_n),
    .cas_n_i(cas_n), .we_n_i(we_n), .ba_i(ba), .addr_i(addr), .dqm_i(dqm),
    .dq_i(dq_o), .dq_o(dq_i), .err_cnt_o(model_errs), .ref_cnt_o(ref_cnt),
    .init_done_o(init_done)
  );

  bind sdram_ctrl_top sdram_ctrl_properties #(.INIT_WAIT_CYC(INIT_WAIT_CYC)) i_props (
    .clk_i(clk_i), .rst_i(rst_i), .ack_o(ack_o), .cs_n_o(cs_n_o), .ras_n_o(ras_n_o),
    .cas_n_o(cas_n_o), .we_n_o(we_n_o), .dqm_o(dqm_o)
  );

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic load_stim();
    int fd;
    int n;
    string line;
    fd = $fopen("dv/sdram_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/sdram_stim.txt");
      other_errs++;
      return;
    end
    while (!$feof(fd) && n_rec < MAX_REC) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h", rec_op[n_rec], rec_adr[n_rec],
                    rec_sel[n_rec], rec_dat[n_rec]);
        if (n == 4) n_rec++;
      end
    end
    $fclose(fd);
  endtask

  // byte-wise merge under sel
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] sel);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  task automatic run_record(input int idx);
    int acks_before;
    int refs_before;
    int key;
    logic [31:0] exp;
    key = int'(rec_adr[idx]);
    acks_before = ack_cnt;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i = rec_op[idx][0];
    adr_i = rec_adr[idx];
    sel_i = rec_sel[idx];
    dat_i = rec_dat[idx];
    do @(negedge clk_i); while (!ack_o);
    if (rec_op[idx][0]) begin
      exp = shadow.exists(key) ? shadow[key] : 32'h0;
      shadow[key] = merge_bytes(exp, rec_dat[idx], rec_sel[idx]);
    end else begin
      exp = shadow.exists(key) ? shadow[key] : 32'h0;
      check_value($sformatf("record %0d read %h", idx, rec_adr[idx]), exp, dat_o);
    end
    cyc_i = 1'b0;
    stb_i = 1'b0;
    refs_before = ref_cnt;
    repeat (GAP_CYC) @(negedge clk_i);
    check_value($sformatf("record %0d ack count", idx), 32'd1, ack_cnt - acks_before);
    if (ref_cnt <= refs_before) begin
      $display("no idle refresh seen in the gap after record %0d", idx);
      other_errs++;
    end
  endtask

  always @(negedge clk_i) begin
    if (ack_o) begin
      ack_cnt++;
      if (!init_done) begin
        $display("ack_o raised before the init sequence finished");
        other_errs++;
      end
    end
  end

  // bank[24:23] row[22:10] col[9:0] of the access in flight
  always @(negedge clk_i) begin
    if (pin_cmd == sdram_pkg::CMD_ACTIVATE) begin
      check_value("activate bank", adr_i[24:23], ba);
      check_value("activate row", adr_i[22:10], addr);
    end else if (pin_cmd == sdram_pkg::CMD_READ || pin_cmd == sdram_pkg::CMD_WRITE) begin
      check_value("column bank", adr_i[24:23], ba);
      check_value("column address", {3'b000, adr_i[9:0]}, addr); // no auto precharge
    end
  end

  initial begin
    rst_i = 1'b1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i = 1'b0;
    adr_i = '0;
    sel_i = '0;
    dat_i = '0;
    load_stim();
    loaded = 1'b1;
    repeat (4) @(negedge clk_i);
    check_value("cke during reset", 32'd0, cke);
    rst_i = 1'b0;
    for (int i = 0; i < n_rec; i++) begin
      run_record(i);
    end
    if (!init_done) begin
      $display("model never saw the init sequence complete");
      other_errs++;
    end
    $display("errors: %0d mismatches, %0d protocol, %0d model, %0d assertion",
             mismatches, other_errs, model_errs, i_sdram_ctrl_top.i_props.assert_fails);
    if (mismatches == 0 && other_errs == 0 && model_errs == 0 &&
        i_sdram_ctrl_top.i_props.assert_fails == 0 && n_rec > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog sized from the record count
  initial begin
    wait (loaded);
    #((n_rec * (40 + GAP_CYC) + INIT_WAIT + 200) * 40);
    $display("timeout: records did not finish within the time bound");
    $display("Test failed");
    $finish;
  end

endmodule

//--- dv/sdram_model.sv
`timescale 1ns/1ns

module sdram_model (
  input  logic mem_clk_i,
  input  logic rst_i,
  input  logic cke_i,
  input  logic cs_n_i,
  input  logic ras_n_i,
  input  logic cas_n_i,
  input  logic we_n_i,
  input  logic [sdram_pkg::BA_W-1:0] ba_i,
  input  logic [sdram_pkg::ROW_W-1:0] addr_i,
  input  logic [sdram_pkg::SEL_W-1:0] dqm_i,
  input  logic [sdram_pkg::DAT_W-1:0] dq_i,
  output logic [sdram_pkg::DAT_W-1:0] dq_o,
  output int err_cnt_o,
  output int ref_cnt_o,
  output logic init_done_o
);

  localparam int CL = sdram_pkg::CAS_LAT;

  logic [31:0] mem [int];          // keyed by {ba, row, col}
  logic [sdram_pkg::ROW_W-1:0] open_row [4];
  logic [3:0] row_open;
  logic [31:0] pipe_data [CL];
  logic [CL-1:0] pipe_vld;
  logic [3:0] cmd;
  int init_step;                   // 0 precharge, 1..8 refresh, 9 mode set

  assign cmd = {cs_n_i, ras_n_i, cas_n_i, we_n_i};

  initial begin
    dq_o = '0;
    err_cnt_o = 0;
    ref_cnt_o = 0;
    init_done_o = 1'b0;
    init_step = 0;
    row_open = '0;
    pipe_vld = '0;
  end

  always @(posedge mem_clk_i) begin
    int key;
    logic [31:0] word;
    if (pipe_vld[CL-1]) dq_o <= pipe_data[CL-1];
    for (int i = CL - 1; i > 0; i--) begin
      pipe_data[i] <= pipe_data[i-1];
      pipe_vld[i] <= pipe_vld[i-1];
    end
    pipe_vld[0] <= 1'b0;
    if (!rst_i && cke_i && cmd != sdram_pkg::CMD_NOP && cmd != sdram_pkg::CMD_DESL) begin
      if (!init_done_o) begin
        if (init_step == 0 && !(cmd == sdram_pkg::CMD_PRECHARGE && addr_i[10])) begin
          $display("model: first command after power-up is not precharge-all");
          err_cnt_o++;
        end else if (init_step >= 1 && init_step <= sdram_pkg::INIT_REFRESHES &&
                     cmd != sdram_pkg::CMD_REFRESH) begin
          $display("model: only %0d refreshes before the next init command", init_step - 1);
          err_cnt_o++;
        end else if (init_step == sdram_pkg::INIT_REFRESHES + 1) begin
          if (cmd != sdram_pkg::CMD_MRS || addr_i != sdram_pkg::MODE_WORD) begin
            $display("model: expected mode set with %h, got command %b addr %h",
                     sdram_pkg::MODE_WORD, cmd, addr_i);
            err_cnt_o++;
          end
          init_done_o <= 1'b1;
        end
        init_step++;
      end else begin
        case (cmd)
          sdram_pkg::CMD_ACTIVATE: begin
            if (row_open[ba_i]) begin
              $display("model: activate on bank %0d which already has a row open", ba_i);
              err_cnt_o++;
            end
            row_open[ba_i] <= 1'b1;
            open_row[ba_i] <= addr_i;
          end
          sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE: begin
            if (!row_open[ba_i]) begin
              $display("model: column access to bank %0d with no open row", ba_i);
              err_cnt_o++;
            end
            key = int'({ba_i, open_row[ba_i], addr_i[sdram_pkg::COL_W-1:0]});
            word = mem.exists(key) ? mem[key] : 32'h0;
            if (cmd == sdram_pkg::CMD_WRITE) begin
              for (int b = 0; b < 4; b++) begin
                if (!dqm_i[b]) word[8*b +: 8] = dq_i[8*b +: 8];
              end
              mem[key] = word;
            end else begin
              pipe_data[0] <= word;
              pipe_vld[0] <= 1'b1;
            end
          end
          sdram_pkg::CMD_PRECHARGE: row_open <= '0; // all banks
          sdram_pkg::CMD_REFRESH: begin
            if (row_open != '0) begin
              $display("model: refresh while a row is still open");
              err_cnt_o++;
            end
            ref_cnt_o++;
          end
          default: begin
            $display("model: unexpected command %b after init", cmd);
            err_cnt_o++;
          end
        endcase
      end
    end
  end

endmodule

//--- dv/sdram_stim.txt
# op(1 write, 0 read) address sel data, all hex
# address bits are bank[24:23] row[22:10] col[9:0], read data is ignored
1 0000405 f 11223344
1 0001c05 f 55667788
1 0800810 f a5a5a5a5
1 1000fff f 0badf00d
1 1fffc01 f deadbeef
0 0000405 f 00000000
0 0001c05 f 00000000
1 0800810 5 00ff00ff
0 0800810 f 00000000
1 1000fff 8 c0000000
0 1000fff f 00000000
0 1fffc01 f 00000000

//--- logic/sdram_cmd_if.sv
`timescale 1ns/1ns

interface sdram_cmd_if;

  sdram_pkg::sdram_cmd_t cmd; // command for the next clock
  logic [sdram_pkg::BA_W-1:0] ba;
  logic [sdram_pkg::ROW_W-1:0] addr;
  logic [sdram_pkg::SEL_W-1:0] dqm;

  modport seq (
    output cmd,
    output ba,
    output addr,
    output dqm
  );

  modport drv (
    input cmd,
    input ba,
    input addr,
    input dqm
  );

endinterface

//--- logic/sdram_ctrl_top.sv
`timescale 1ns/1ns

module sdram_ctrl_top #(
  parameter int INIT_WAIT_CYC = 20000
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic cyc_i,
  input  logic stb_i,
  input  logic we_i,
  input  logic [sdram_pkg::ADR_W-1:0] adr_i,
  input  logic [sdram_pkg::SEL_W-1:0] sel_i,
  input  logic [sdram_pkg::DAT_W-1:0] dat_i,
  output logic [sdram_pkg::DAT_W-1:0] dat_o,
  output logic ack_o,
  output logic mem_clk_o,
  output logic cke_o,
  output logic cs_n_o,
  output logic ras_n_o,
  output logic cas_n_o,
  output logic we_n_o,
  output logic [sdram_pkg::BA_W-1:0] ba_o,
  output logic [sdram_pkg::ROW_W-1:0] addr_o,
  output logic [sdram_pkg::SEL_W-1:0] dqm_o,
  input  logic [sdram_pkg::DAT_W-1:0] dq_i,
  output logic [sdram_pkg::DAT_W-1:0] dq_o
);

  logic tmr_load;
  logic [sdram_pkg::DELAY_W-1:0] tmr_val;
  logic tmr_zero;
  logic tmr_sub_zero;
  logic wr_load;
  logic rd_capture;

  sdram_cmd_if cmd_if ();

  sdram_sequencer #(
    .INIT_WAIT_CYC(INIT_WAIT_CYC)
  ) i_sequencer (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .cyc_i(cyc_i),
    .stb_i(stb_i),
    .we_i(we_i),
    .adr_i(adr_i),
    .sel_i(sel_i),
    .tmr_zero_i(tmr_zero),
    .tmr_sub_zero_i(tmr_sub_zero),
    .tmr_load_o(tmr_load),
    .tmr_val_o(tmr_val),
    .wr_load_o(wr_load),
    .rd_capture_o(rd_capture),
    .ack_o(ack_o),
    .cmd_if(cmd_if.seq)
  );

  sdram_delay_timer i_timer (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .load_i(tmr_load),
    .val_i(tmr_val),
    .zero_o(tmr_zero),
    .sub_zero_o(tmr_sub_zero)
  );

  sdram_pin_driver i_pin_driver (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .cmd_if(cmd_if.drv),
    .mem_clk_o(mem_clk_o),
    .cke_o(cke_o),
    .cs_n_o(cs_n_o),
    .ras_n_o(ras_n_o),
    .cas_n_o(cas_n_o),
    .we_n_o(we_n_o),
    .ba_o(ba_o),
    .addr_o(addr_o),
    .dqm_o(dqm_o)
  );

  sdram_data_path i_data_path (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .wr_load_i(wr_load),
    .rd_capture_i(rd_capture),
    .dat_i(dat_i),
    .dq_i(dq_i),
    .dq_o(dq_o),
    .dat_o(dat_o)
  );

endmodule

//--- logic/sdram_data_path.sv
`timescale 1ns/1ns

module sdram_data_path (
  input  logic clk_i,
  input  logic rst_i,
  input  logic wr_load_i,
  input  logic rd_capture_i,
  input  logic [sdram_pkg::DAT_W-1:0] dat_i,
  input  logic [sdram_pkg::DAT_W-1:0] dq_i,
  output logic [sdram_pkg::DAT_W-1:0] dq_o,
  output logic [sdram_pkg::DAT_W-1:0] dat_o
);

  localparam int CL = sdram_pkg::CAS_LAT;

  logic [CL:0] rd_pipe_q; // read strobe delayed to the data beat
  logic [sdram_pkg::DAT_W-1:0] wr_data_q;
  logic [sdram_pkg::DAT_W-1:0] rd_data_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_pipe_q <= '0;
    end else begin
      rd_pipe_q <= {rd_pipe_q[CL-1:0], rd_capture_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_load_i) begin
      wr_data_q <= dat_i;
    end
    if (rd_pipe_q[CL]) begin
      rd_data_q <= dq_i; // stable while ack is high
    end
  end

  assign dq_o = wr_data_q;
  assign dat_o = rd_data_q;

endmodule

//--- logic/sdram_delay_timer.sv
`timescale 1ns/1ns

module sdram_delay_timer (
  input  logic clk_i,
  input  logic rst_i,
  input  logic load_i,
  input  logic [sdram_pkg::DELAY_W-1:0] val_i,
  output logic zero_o,
  output logic sub_zero_o
);

  logic [sdram_pkg::DELAY_W-1:0] count_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= val_i;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1; // holds at zero
    end
  end

  assign zero_o = (count_q == '0);
  assign sub_zero_o = (count_q[2:0] == 3'd0); // init refresh spacing

endmodule

//--- logic/sdram_pin_driver.sv
`timescale 1ns/1ns

module sdram_pin_driver (
  input  logic clk_i,
  input  logic rst_i,
  sdram_cmd_if.drv cmd_if,
  output logic mem_clk_o,
  output logic cke_o,
  output logic cs_n_o,
  output logic ras_n_o,
  output logic cas_n_o,
  output logic we_n_o,
  output logic [sdram_pkg::BA_W-1:0] ba_o,
  output logic [sdram_pkg::ROW_W-1:0] addr_o,
  output logic [sdram_pkg::SEL_W-1:0] dqm_o
);

  sdram_pkg::sdram_cmd_t cmd_q;
  logic cke_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cmd_q <= sdram_pkg::CMD_NOP;
      cke_q <= 1'b0;
      ba_o <= '0;
      addr_o <= '0;
      dqm_o <= '1;
    end else begin
      cmd_q <= cmd_if.cmd;
      cke_q <= 1'b1;
      dqm_o <= cmd_if.dqm;
      if (cmd_if.cmd != sdram_pkg::CMD_NOP) begin
        ba_o <= cmd_if.ba; // address held across NOPs
        addr_o <= cmd_if.addr;
      end
    end
  end

  assign {cs_n_o, ras_n_o, cas_n_o, we_n_o} = cmd_q;
  assign cke_o = cke_q;
  assign mem_clk_o = ~clk_i; // memory samples mid cycle

endmodule

//--- logic/sdram_pkg.sv
package sdram_pkg;

  // geometry
  localparam int ADR_W = 25;
  localparam int BA_W = 2;
  localparam int ROW_W = 13;
  localparam int COL_W = 10;
  localparam int DAT_W = 32;
  localparam int SEL_W = 4;

  localparam int DELAY_W = 16;

  // timing in controller clocks
  localparam int T_RCD_CYC = 5;
  localparam int T_RFC_CYC = 9;
  localparam int T_MRD_CYC = 4;
  localparam int INIT_REFRESHES = 8;
  localparam int CAS_LAT = 2;

  // write single location, CAS 2, sequential, burst length 1
  localparam logic [ROW_W-1:0] MODE_WORD = 13'b0_0010_0010_0000;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_DESL      = 4'b1111,
    CMD_NOP       = 4'b0111,
    CMD_READ      = 4'b0101,
    CMD_WRITE     = 4'b0100,
    CMD_ACTIVATE  = 4'b0011,
    CMD_PRECHARGE = 4'b0010,
    CMD_REFRESH   = 4'b0001,
    CMD_MRS       = 4'b0000
  } sdram_cmd_t;

  typedef enum logic [3:0] {
    S_INIT_START,
    S_INIT_WAIT,
    S_INIT_PRE,
    S_INIT_REF,
    S_INIT_MODE,
    S_IDLE,
    S_REFRESH,
    S_ACTIVATE,
    S_READ_WAIT,
    S_ACK,
    S_PRECHARGE
  } seq_state_t;

endpackage

//--- logic/sdram_sequencer.sv
`timescale 1ns/1ns

module sdram_sequencer #(
  parameter int INIT_WAIT_CYC = 20000
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic cyc_i,
  input  logic stb_i,
  input  logic we_i,
  input  logic [sdram_pkg::ADR_W-1:0] adr_i,
  input  logic [sdram_pkg::SEL_W-1:0] sel_i,
  input  logic tmr_zero_i,
  input  logic tmr_sub_zero_i,
  output logic tmr_load_o,
  output logic [sdram_pkg::DELAY_W-1:0] tmr_val_o,
  output logic wr_load_o,
  output logic rd_capture_o,
  output logic ack_o,
  sdram_cmd_if.seq cmd_if
);

  localparam int DW = sdram_pkg::DELAY_W;
  localparam int RW = sdram_pkg::ROW_W;

  // wait values, timer reaches zero one cycle before the next step
  localparam logic [DW-1:0] INIT_WAIT_VAL = DW'(INIT_WAIT_CYC - 1);
  localparam logic [DW-1:0] RP_VAL = DW'(sdram_pkg::T_RCD_CYC - 1);
  localparam logic [DW-1:0] INIT_REF_VAL = DW'(sdram_pkg::INIT_REFRESHES * 8 - 1);
  localparam logic [DW-1:0] MRD_VAL = DW'(sdram_pkg::T_MRD_CYC - 1);
  localparam logic [DW-1:0] RCD_VAL = DW'(sdram_pkg::T_RCD_CYC - 1);
  localparam logic [DW-1:0] RFC_VAL = DW'(sdram_pkg::T_RFC_CYC - 2);
  localparam logic [DW-1:0] CL_VAL = DW'(sdram_pkg::CAS_LAT);
  localparam logic [RW-1:0] ADDR_A10 = {{(RW - 11){1'b0}}, 1'b1, 10'b0}; // all banks

  sdram_pkg::seq_state_t state_q;
  sdram_pkg::seq_state_t state_next;
  logic ack_q;
  logic req;
  logic [sdram_pkg::BA_W-1:0] bank;
  logic [RW-1:0] row;
  logic [RW-1:0] col_addr;

  assign req = cyc_i & stb_i;
  assign bank = adr_i[sdram_pkg::ADR_W-1 -: sdram_pkg::BA_W];
  assign row = adr_i[sdram_pkg::COL_W +: RW];
  assign col_addr = {{(RW - sdram_pkg::COL_W){1'b0}}, adr_i[sdram_pkg::COL_W-1:0]}; // A10 low

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= sdram_pkg::S_INIT_START;
      ack_q <= 1'b0;
    end else begin
      state_q <= state_next;
      ack_q <= (state_next == sdram_pkg::S_ACK);
    end
  end

  assign ack_o = ack_q;

  always_comb begin
    state_next = state_q;
    cmd_if.cmd = sdram_pkg::CMD_NOP;
    cmd_if.ba = bank;
    cmd_if.addr = row;
    cmd_if.dqm = '1;
    tmr_load_o = 1'b0;
    tmr_val_o = '0;
    wr_load_o = 1'b0;
    rd_capture_o = 1'b0;
    case (state_q)
      sdram_pkg::S_INIT_START: begin
        tmr_load_o = 1'b1;
        tmr_val_o = INIT_WAIT_VAL;
        state_next = sdram_pkg::S_INIT_WAIT;
      end
      sdram_pkg::S_INIT_WAIT: begin
        if (tmr_zero_i) begin
          cmd_if.cmd = sdram_pkg::CMD_PRECHARGE;
          cmd_if.addr = ADDR_A10;
          tmr_load_o = 1'b1;
          tmr_val_o = RP_VAL;
          state_next = sdram_pkg::S_INIT_PRE;
        end
      end
      sdram_pkg::S_INIT_PRE: begin
        if (tmr_zero_i) begin
          cmd_if.cmd = sdram_pkg::CMD_REFRESH; // first of the init refreshes
          tmr_load_o = 1'b1;
          tmr_val_o = INIT_REF_VAL;
          state_next = sdram_pkg::S_INIT_REF;
        end
      end
      sdram_pkg::S_INIT_REF: begin
        if (tmr_zero_i) begin
          cmd_if.cmd = sdram_pkg::CMD_MRS;
          cmd_if.ba = '0;
          cmd_if.addr = sdram_pkg::MODE_WORD;
          tmr_load_o = 1'b1;
          tmr_val_o = MRD_VAL;
          state_next = sdram_pkg::S_INIT_MODE;
        end else if (tmr_sub_zero_i) begin
          cmd_if.cmd = sdram_pkg::CMD_REFRESH; // every 8 cycles
        end
      end
      sdram_pkg::S_INIT_MODE: begin
        if (tmr_zero_i) begin
          state_next = sdram_pkg::S_IDLE;
        end
      end
      sdram_pkg::S_IDLE: begin
        tmr_load_o = 1'b1;
        if (req) begin
          cmd_if.cmd = sdram_pkg::CMD_ACTIVATE; // open row
          tmr_val_o = RCD_VAL;
          state_next = sdram_pkg::S_ACTIVATE;
        end else begin
          cmd_if.cmd = sdram_pkg::CMD_REFRESH;
          cmd_if.addr = ADDR_A10;
          tmr_val_o = RFC_VAL;
          state_next = sdram_pkg::S_REFRESH;
        end
      end
      sdram_pkg::S_REFRESH: begin
        if (tmr_zero_i) begin
          state_next = sdram_pkg::S_IDLE;
        end
      end
      sdram_pkg::S_ACTIVATE: begin
        if (tmr_zero_i) begin
          cmd_if.addr = col_addr;
          cmd_if.dqm = ~sel_i;
          if (we_i) begin
            cmd_if.cmd = sdram_pkg::CMD_WRITE;
            wr_load_o = 1'b1;
            state_next = sdram_pkg::S_ACK;
          end else begin
            cmd_if.cmd = sdram_pkg::CMD_READ;
            rd_capture_o = 1'b1;
            tmr_load_o = 1'b1;
            tmr_val_o = CL_VAL;
            state_next = sdram_pkg::S_READ_WAIT;
          end
        end
      end
      sdram_pkg::S_READ_WAIT: begin
        if (tmr_zero_i) begin
          state_next = sdram_pkg::S_ACK; // data captured on this edge
        end
      end
      sdram_pkg::S_ACK: begin
        cmd_if.cmd = sdram_pkg::CMD_PRECHARGE;
        cmd_if.addr = ADDR_A10;
        state_next = sdram_pkg::S_PRECHARGE;
      end
      sdram_pkg::S_PRECHARGE: begin
        state_next = sdram_pkg::S_IDLE;
      end
      default: begin
        state_next = sdram_pkg::S_IDLE;
      end
    endcase
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module sdram_ctrl_tb -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status, see sim.log"
  exit 1
fi

if grep -q "^Test passed$" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- vlog.f
logic/sdram_pkg.sv
logic/sdram_cmd_if.sv
logic/sdram_delay_timer.sv
logic/sdram_pin_driver.sv
logic/sdram_data_path.sv
logic/sdram_sequencer.sv
logic/sdram_ctrl_top.sv
dv/sdram_model.sv
dv/sdram_ctrl_properties.sv
dv/sdram_ctrl_tb.sv
